// ==== sources.f ====
hw/bram_bus_pkg.sv
hw/burst_ctrl_pkg.sv
hw/line_cache.sv
hw/read_burst_engine.sv
hw/write_burst_engine.sv
hw/bram_arbiter.sv
hw/half_duplex_ctrl.sv
test/tb_half_duplex.sv

// ==== test/tb_half_duplex.sv ====
`timescale 1ns/1ps

module tb_half_duplex
	import bram_bus_pkg::*, burst_ctrl_pkg::*;
();

	localparam int ADDR_W      = BRAM_ADDR_W_DEF;
	localparam int DATA_W      = BRAM_DATA_W_DEF;
	localparam int CACHE_DEPTH = CACHE_DEPTH_DEF;
	localparam int READ_LAT    = BRAM_READ_LAT_DEF;
	localparam int CNT_W       = $clog2(CACHE_DEPTH) + 1;
	localparam int MAX_BURST   = 16;
	localparam int N_MIXED     = 20;
	// Two bursts each in the directed tests, up to two per mixed round
	localparam int N_BURSTS    = 4 + 2 * N_MIXED;
	localparam int CYCLE_LIMIT = N_BURSTS * MAX_BURST * (READ_LAT + 6) + 2000;

	logic              clk;
	logic              resetN;
	logic              i_read_req;
	logic [ADDR_W-1:0] i_read_addr;
	burst_len_t        i_num_reads;
	logic              i_advance_buffer;
	logic [DATA_W-1:0] o_request_data;
	logic              i_write_req;
	logic [ADDR_W-1:0] i_write_addr;
	burst_len_t        i_num_writes;
	logic              i_pulse_write;
	logic [DATA_W-1:0] i_send_data;
	logic [CNT_W-1:0]  o_wr_data_count;
	logic              o_data_valid;
	logic              o_bram_en;
	logic              o_bram_we;
	logic [ADDR_W-1:0] o_bram_addr;
	logic [DATA_W-1:0] o_bram_wdata;
	logic [DATA_W-1:0] i_bram_rdata;

	// RAM model, reference memory and write cache model
	logic [DATA_W-1:0] ram [logic [ADDR_W-1:0]];
	logic [DATA_W-1:0] ref_mem [logic [ADDR_W-1:0]];
	logic [DATA_W-1:0] rd_pipe [READ_LAT];
	logic [DATA_W-1:0] wr_q [$];
	logic [ADDR_W-1:0] written_q [$];
	logic              rd_busy;
	int                cycles = 0;
	int                err_cnt = 0;
	int unsigned       seed;

	half_duplex_ctrl #(
		.ADDR_W      (ADDR_W),
		.DATA_W      (DATA_W),
		.CACHE_DEPTH (CACHE_DEPTH),
		.READ_LAT    (READ_LAT)
	) u_dut (
		.clk              (clk),
		.resetN           (resetN),
		.i_read_req       (i_read_req),
		.i_read_addr      (i_read_addr),
		.i_num_reads      (i_num_reads),
		.i_advance_buffer (i_advance_buffer),
		.o_request_data   (o_request_data),
		.i_write_req      (i_write_req),
		.i_write_addr     (i_write_addr),
		.i_num_writes     (i_num_writes),
		.i_pulse_write    (i_pulse_write),
		.i_send_data      (i_send_data),
		.o_wr_data_count  (o_wr_data_count),
		.o_data_valid     (o_data_valid),
		.o_bram_en        (o_bram_en),
		.o_bram_we        (o_bram_we),
		.o_bram_addr      (o_bram_addr),
		.o_bram_wdata     (o_bram_wdata),
		.i_bram_rdata     (i_bram_rdata)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Unwritten words, unique per address
	function automatic logic [DATA_W-1:0] fill_word(input logic [ADDR_W-1:0] a);
		return (DATA_W'(a) * DATA_W'(32'h0001_0003)) ^ DATA_W'(32'h5A5A_A5A5);
	endfunction

	task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp) begin
			err_cnt++;
			$display("mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
			$display("=== FAIL ===");
			$fatal(1, "stopped at first error");
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// RAM model and bus monitor, sampled at the rising edge

	always @(posedge clk) begin
		if (o_bram_en && o_bram_we) begin
			ram[o_bram_addr] = o_bram_wdata;
		end
		// Read priority, no write while a read is outstanding
		if (rd_busy && o_bram_en) begin
			compare("o_bram_we", o_bram_we, 0);
		end
		for (int i = READ_LAT - 1; i > 0; i--) begin
			rd_pipe[i] = rd_pipe[i-1];
		end
		if (o_bram_en && !o_bram_we) begin
			rd_pipe[0] = ram.exists(o_bram_addr) ? ram[o_bram_addr] : fill_word(o_bram_addr);
		end
		#1 i_bram_rdata = rd_pipe[READ_LAT-1];
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > CYCLE_LIMIT) begin
			$display("timeout: no end of the run after %0d cycles", CYCLE_LIMIT);
			$display("=== FAIL ===");
			$fatal(1, "timeout");
		end
	end

	task automatic step_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic expect_idle();
		compare("o_bram_en", o_bram_en, 0);
		compare("o_bram_we", o_bram_we, 0);
		compare("o_data_valid", o_data_valid, 0);
		compare("o_wr_data_count", o_wr_data_count, 0);
	endtask

	// One strobe edge, count checked a cycle later
	task automatic push_word(input logic [DATA_W-1:0] data);
		i_send_data   = data;
		i_pulse_write = 1'b1;
		step_cycle();
		i_pulse_write = 1'b0;
		wr_q.push_back(data);
		step_cycle();
		compare("o_wr_data_count", o_wr_data_count, wr_q.size());
	endtask

	// Enough words for the burst, sometimes a few spare
	task automatic fill_cache(input int n);
		int extra;
		extra = $urandom_range(0, 2);
		while (wr_q.size() < n + extra) begin
			push_word(DATA_W'($urandom));
		end
	endtask

	// Contiguous run of already written addresses
	task automatic pick_read_range(output logic [ADDR_W-1:0] ra, output int rn);
		ra = written_q[$urandom_range(0, written_q.size() - 1)];
		rn = 1;
		while (rn < MAX_BURST && ref_mem.exists(ra + ADDR_W'(rn))
				&& $urandom_range(0, 7) != 0) begin
			rn++;
		end
	endtask

	task automatic run_bursts(input bit do_wr, input logic [ADDR_W-1:0] wa, input int wn,
			input bit do_rd, input logic [ADDR_W-1:0] ra, input int rn);
		logic [DATA_W-1:0] exp_rd [$];
		logic [ADDR_W-1:0] a;
		int                pulses;
		// Read wins, so it sees memory from before the write
		for (int i = 0; i < rn && do_rd; i++) begin
			a = ra + ADDR_W'(i);
			exp_rd.push_back(ref_mem[a]);
		end
		for (int i = 0; i < wn && do_wr; i++) begin
			a = wa + ADDR_W'(i);
			ref_mem[a] = wr_q.pop_front();
			written_q.push_back(a);
		end
		i_write_addr = wa;
		i_num_writes = burst_len_t'(wn);
		i_write_req  = do_wr;
		i_read_addr  = ra;
		i_num_reads  = burst_len_t'(rn);
		i_read_req   = do_rd;
		rd_busy      = do_rd;
		step_cycle();
		i_write_req  = 1'b0;
		i_read_req   = 1'b0;
		pulses = 0;
		while (pulses < int'(do_wr) + int'(do_rd)) begin
			if (o_data_valid) begin
				pulses++;
				rd_busy = 1'b0;
			end
			step_cycle();
		end
		// Exactly one pulse per burst
		repeat (2) begin
			compare("o_data_valid", o_data_valid, 0);
			step_cycle();
		end
		for (int i = 0; i < wn && do_wr; i++) begin
			a = wa + ADDR_W'(i);
			compare("bram word", ram[a], ref_mem[a]);
		end
		compare("o_wr_data_count", o_wr_data_count, wr_q.size());
		// Drain the read cache in address order
		for (int i = 0; i < rn && do_rd; i++) begin
			compare("o_request_data", o_request_data, exp_rd[i]);
			i_advance_buffer = 1'b1;
			step_cycle();
			i_advance_buffer = 1'b0;
			step_cycle();
		end
	endtask

	initial begin
		logic [ADDR_W-1:0] wa;
		logic [ADDR_W-1:0] ra;
		int                wn;
		int                rn;
		int                mode;
		seed = $urandom(41);
		resetN           = 1'b0;
		i_read_req       = 1'b0;
		i_read_addr      = '0;
		i_num_reads      = '0;
		i_advance_buffer = 1'b0;
		i_write_req      = 1'b0;
		i_write_addr     = '0;
		i_num_writes     = '0;
		i_pulse_write    = 1'b0;
		i_send_data      = '0;
		i_bram_rdata     = '0;
		rd_busy          = 1'b0;

		// Outputs quiet during and right after reset
		repeat (10) begin
			step_cycle();
			expect_idle();
		end
		resetN = 1'b1;
		step_cycle();
		expect_idle();

		// Pushes, then one write burst and its read back
		wa = ADDR_W'($urandom);
		wn = $urandom_range(1, MAX_BURST);
		fill_cache(wn);
		run_bursts(1'b1, wa, wn, 1'b0, '0, 0);
		run_bursts(1'b0, '0, 0, 1'b1, wa, wn);

		// Requests in the same cycle
		wa = ADDR_W'($urandom);
		wn = $urandom_range(1, MAX_BURST);
		fill_cache(wn);
		pick_read_range(ra, rn);
		run_bursts(1'b1, wa, wn, 1'b1, ra, rn);

		////////////////////////////////////////////////////////////////////////////
		// Random mix of write, read and simultaneous bursts

		for (int k = 0; k < N_MIXED; k++) begin
			mode = $urandom_range(0, 2);
			wa   = ADDR_W'($urandom);
			wn   = $urandom_range(1, MAX_BURST);
			pick_read_range(ra, rn);
			if (mode != 1) begin
				fill_cache(wn);
			end
			run_bursts(mode != 1, wa, (mode != 1) ? wn : 0, mode != 0, ra, (mode != 0) ? rn : 0);
		end

		if (err_cnt == 0) begin
			$display("=== PASS ===");
			$finish;
		end else begin
			$display("=== FAIL ===");
			$fatal(1, "errors found");
		end
	end

endmodule

// ==== hw/half_duplex_ctrl.sv ====
`timescale 1ns/1ps

module half_duplex_ctrl
	import bram_bus_pkg::*, burst_ctrl_pkg::*;
#(
	parameter int ADDR_W      = BRAM_ADDR_W_DEF,
	parameter int DATA_W      = BRAM_DATA_W_DEF,
	parameter int CACHE_DEPTH = CACHE_DEPTH_DEF,
	parameter int READ_LAT    = BRAM_READ_LAT_DEF
) (
	input  logic                         clk,
	input  logic                         resetN,
	// Host read side
	input  logic                         i_read_req,
	input  logic [ADDR_W-1:0]            i_read_addr,
	input  burst_len_t                   i_num_reads,
	input  logic                         i_advance_buffer,
	output logic [DATA_W-1:0]            o_request_data,
	// Host write side
	input  logic                         i_write_req,
	input  logic [ADDR_W-1:0]            i_write_addr,
	input  burst_len_t                   i_num_writes,
	input  logic                         i_pulse_write,
	input  logic [DATA_W-1:0]            i_send_data,
	output logic [$clog2(CACHE_DEPTH):0] o_wr_data_count,
	output logic                         o_data_valid,
	// RAM port
	output logic                         o_bram_en,
	output logic                         o_bram_we,
	output logic [ADDR_W-1:0]            o_bram_addr,
	output logic [DATA_W-1:0]            o_bram_wdata,
	input  logic [DATA_W-1:0]            i_bram_rdata
);

	// Engine to arbiter wiring
	logic              rd_claim;
	logic              rd_grant;
	logic              rd_en;
	logic              rd_done;
	logic [ADDR_W-1:0] rd_addr;
	logic              wr_claim;
	logic              wr_grant;
	logic              wr_en;
	logic              wr_we;
	logic              wr_done;
	logic [ADDR_W-1:0] wr_addr;
	logic [DATA_W-1:0] wr_wdata;

	read_burst_engine #(
		.ADDR_W      (ADDR_W),
		.DATA_W      (DATA_W),
		.CACHE_DEPTH (CACHE_DEPTH),
		.READ_LAT    (READ_LAT)
	) u_read_engine (
		.clk              (clk),
		.resetN           (resetN),
		.i_read_req       (i_read_req),
		.i_read_addr      (i_read_addr),
		.i_num_reads      (i_num_reads),
		.i_advance_buffer (i_advance_buffer),
		.o_request_data   (o_request_data),
		.i_grant          (rd_grant),
		.i_bram_rdata     (i_bram_rdata),
		.o_claim          (rd_claim),
		.o_bus_en         (rd_en),
		.o_bus_addr       (rd_addr),
		.o_burst_done     (rd_done)
	);

	write_burst_engine #(
		.ADDR_W      (ADDR_W),
		.DATA_W      (DATA_W),
		.CACHE_DEPTH (CACHE_DEPTH)
	) u_write_engine (
		.clk             (clk),
		.resetN          (resetN),
		.i_write_req     (i_write_req),
		.i_write_addr    (i_write_addr),
		.i_num_writes    (i_num_writes),
		.i_pulse_write   (i_pulse_write),
		.i_send_data     (i_send_data),
		.o_wr_data_count (o_wr_data_count),
		.i_grant         (wr_grant),
		.o_claim         (wr_claim),
		.o_bus_en        (wr_en),
		.o_bus_we        (wr_we),
		.o_bus_addr      (wr_addr),
		.o_bus_wdata     (wr_wdata),
		.o_burst_done    (wr_done)
	);

	// Single RAM port shared through the semaphore
	bram_arbiter #(
		.ADDR_W (ADDR_W),
		.DATA_W (DATA_W)
	) u_arbiter (
		.clk          (clk),
		.resetN       (resetN),
		.i_rd_claim   (rd_claim),
		.i_rd_done    (rd_done),
		.i_rd_en      (rd_en),
		.i_rd_addr    (rd_addr),
		.i_wr_claim   (wr_claim),
		.i_wr_done    (wr_done),
		.i_wr_en      (wr_en),
		.i_wr_we      (wr_we),
		.i_wr_addr    (wr_addr),
		.i_wr_wdata   (wr_wdata),
		.o_rd_grant   (rd_grant),
		.o_wr_grant   (wr_grant),
		.o_bram_en    (o_bram_en),
		.o_bram_we    (o_bram_we),
		.o_bram_addr  (o_bram_addr),
		.o_bram_wdata (o_bram_wdata),
		.o_data_valid (o_data_valid)
	);

endmodule

// ==== hw/bram_arbiter.sv ====
`timescale 1ns/1ps

module bram_arbiter
	import bram_bus_pkg::*, burst_ctrl_pkg::*;
#(
	parameter int ADDR_W = BRAM_ADDR_W_DEF,
	parameter int DATA_W = BRAM_DATA_W_DEF
) (
	input  logic              clk,
	input  logic              resetN,
	// Read engine
	input  logic              i_rd_claim,
	input  logic              i_rd_done,
	input  logic              i_rd_en,
	input  logic [ADDR_W-1:0] i_rd_addr,
	// Write engine
	input  logic              i_wr_claim,
	input  logic              i_wr_done,
	input  logic              i_wr_en,
	input  logic              i_wr_we,
	input  logic [ADDR_W-1:0] i_wr_addr,
	input  logic [DATA_W-1:0] i_wr_wdata,
	// Grants back to the engines
	output logic              o_rd_grant,
	output logic              o_wr_grant,
	// RAM port and host pulse
	output logic              o_bram_en,
	output logic              o_bram_we,
	output logic [ADDR_W-1:0] o_bram_addr,
	output logic [DATA_W-1:0] o_bram_wdata,
	output logic              o_data_valid
);

	bus_owner_t owner;

	////////////////////////////////////////////////////////////////////////////
	// Semaphore, set wins over release, read wins over write

	always_ff @(posedge clk) begin
		if (!resetN) begin
			owner <= owner_none;
		end else if (i_rd_claim && owner == owner_none) begin
			owner <= owner_read;
		end else if (i_wr_claim && owner == owner_none) begin
			owner <= owner_write;
		end else if (i_rd_done && owner == owner_read) begin
			owner <= owner_none;
		end else if (i_wr_done && owner == owner_write) begin
			owner <= owner_none;
		end
	end

	assign o_rd_grant = (owner == owner_read);
	assign o_wr_grant = (owner == owner_write);

	// Owner's signals reach the RAM, all zero with no owner
	always_comb begin
		o_bram_en    = 1'b0;
		o_bram_we    = 1'b0;
		o_bram_addr  = '0;
		o_bram_wdata = '0;
		case (owner)
			owner_read: begin
				o_bram_en   = i_rd_en;
				o_bram_addr = i_rd_addr;
			end
			owner_write: begin
				o_bram_en    = i_wr_en;
				o_bram_we    = i_wr_we;
				o_bram_addr  = i_wr_addr;
				o_bram_wdata = i_wr_wdata;
			end
			default: ;
		endcase
	end

	// One pulse at the end of either burst
	assign o_data_valid = i_rd_done || i_wr_done;

	// Only the granted engine drives its port enable
	a_one_enable: assert property (@(posedge clk) disable iff (!resetN)
		!(i_rd_en && i_wr_en))
		else $error("bram_arbiter: both engines enable the port");

	// Write engine stays off the port during a read burst
	a_no_we_in_read: assert property (@(posedge clk) disable iff (!resetN)
		(owner == owner_read) |-> !i_wr_we)
		else $error("bram_arbiter: write enable during read ownership");

endmodule

// ==== hw/write_burst_engine.sv ====
`timescale 1ns/1ps

module write_burst_engine
	import bram_bus_pkg::*, burst_ctrl_pkg::*;
#(
	parameter int ADDR_W      = BRAM_ADDR_W_DEF,
	parameter int DATA_W      = BRAM_DATA_W_DEF,
	parameter int CACHE_DEPTH = CACHE_DEPTH_DEF
) (
	input  logic                         clk,
	input  logic                         resetN,
	// Host side
	input  logic                         i_write_req,
	input  logic [ADDR_W-1:0]            i_write_addr,
	input  burst_len_t                   i_num_writes,
	input  logic                         i_pulse_write,
	input  logic [DATA_W-1:0]            i_send_data,
	output logic [$clog2(CACHE_DEPTH):0] o_wr_data_count,
	// Arbiter side
	input  logic                         i_grant,
	output logic                         o_claim,
	output logic                         o_bus_en,
	output logic                         o_bus_we,
	output logic [ADDR_W-1:0]            o_bus_addr,
	output logic [DATA_W-1:0]            o_bus_wdata,
	output logic                         o_burst_done
);

	wr_state_t         state;
	wr_state_t         next_state;
	logic [ADDR_W-1:0] addr_q;
	burst_len_t        target;
	burst_len_t        word_cnt;
	burst_len_t        num_eff;
	logic              pulse_q;
	logic              push;
	logic              start;

	// Rising edge of the write strobe pushes one host word
	assign push = i_pulse_write && !pulse_q;

	// Zero words still writes one
	assign num_eff = (i_num_writes == '0) ? burst_len_t'(1) : i_num_writes;
	assign start   = (state == wr_idle) && i_write_req;

	////////////////////////////////////////////////////////////////////////////
	// State and strobe history

	always_ff @(posedge clk) begin
		if (!resetN) begin
			state   <= wr_idle;
			pulse_q <= 1'b0;
		end else begin
			state   <= next_state;
			pulse_q <= i_pulse_write;
		end
	end

	// Address and counters, cleared at every burst start
	always_ff @(posedge clk) begin
		if (start) begin
			addr_q   <= i_write_addr;
			target   <= num_eff;
			word_cnt <= '0;
		end else if (state == wr_remove) begin
			addr_q   <= addr_q + 1'b1;
			word_cnt <= word_cnt + 1'b1;
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			wr_idle:   if (i_write_req) next_state = wr_claim;
			wr_claim:  if (i_grant) next_state = wr_enable;
			wr_enable: next_state = wr_assert;
			wr_assert: next_state = wr_remove;
			wr_remove: next_state = wr_pause;
			// Count already updated by the remove cycle
			wr_pause:  next_state = (word_cnt < target) ? wr_enable : wr_done;
			wr_done:   next_state = wr_idle;
			default:   next_state = wr_idle;
		endcase
	end

	assign o_claim      = state inside {wr_claim, wr_enable, wr_assert, wr_remove, wr_pause};
	assign o_bus_en     = state inside {wr_enable, wr_assert, wr_remove};
	// Cache head is stored at the current address
	assign o_bus_we     = (state == wr_assert);
	assign o_bus_addr   = addr_q;
	assign o_burst_done = (state == wr_done);

	// Write cache, filled by the host, drained into the RAM
	line_cache #(
		.DATA_W      (DATA_W),
		.CACHE_DEPTH (CACHE_DEPTH)
	) u_write_cache (
		.clk         (clk),
		.resetN      (resetN),
		.i_push      (push),
		.i_push_data (i_send_data),
		.i_pop       (state == wr_remove),
		.o_head      (o_bus_wdata),
		.o_empty     (),
		.o_full      (),
		.o_count     (o_wr_data_count)
	);

	// Host must have the whole burst cached before asking for it
	a_burst_cached: assert property (@(posedge clk) disable iff (!resetN)
		start |-> (32'(o_wr_data_count) >= 32'(num_eff)))
		else $error("write_burst_engine: burst of %0d words, only %0d cached",
			num_eff, o_wr_data_count);

endmodule

// ==== hw/read_burst_engine.sv ====
`timescale 1ns/1ps

module read_burst_engine
	import bram_bus_pkg::*, burst_ctrl_pkg::*;
#(
	parameter int ADDR_W      = BRAM_ADDR_W_DEF,
	parameter int DATA_W      = BRAM_DATA_W_DEF,
	parameter int CACHE_DEPTH = CACHE_DEPTH_DEF,
	parameter int READ_LAT    = BRAM_READ_LAT_DEF
) (
	input  logic              clk,
	input  logic              resetN,
	// Host side
	input  logic              i_read_req,
	input  logic [ADDR_W-1:0] i_read_addr,
	input  burst_len_t        i_num_reads,
	input  logic              i_advance_buffer,
	output logic [DATA_W-1:0] o_request_data,
	// Arbiter side
	input  logic              i_grant,
	input  logic [DATA_W-1:0] i_bram_rdata,
	output logic              o_claim,
	output logic              o_bus_en,
	output logic [ADDR_W-1:0] o_bus_addr,
	output logic              o_burst_done
);

	localparam int LAT_W = $clog2(READ_LAT + 1);

	rd_state_t         state;
	rd_state_t         next_state;
	logic [ADDR_W-1:0] addr_q;
	burst_len_t        target;
	burst_len_t        word_cnt;
	burst_len_t        num_eff;
	logic [LAT_W-1:0]  lat_cnt;
	logic              adv_q;
	logic              pop;
	logic              start;

	// Rising edge of the advance strobe pops one word
	assign pop = i_advance_buffer && !adv_q;

	// Zero words still reads one
	assign num_eff = (i_num_reads == '0) ? burst_len_t'(1) : i_num_reads;
	assign start   = (state == rd_idle) && i_read_req;

	////////////////////////////////////////////////////////////////////////////
	// State and strobe history

	always_ff @(posedge clk) begin
		if (!resetN) begin
			state <= rd_idle;
			adv_q <= 1'b0;
		end else begin
			state <= next_state;
			adv_q <= i_advance_buffer;
		end
	end

	// Address, target and counters, cleared at every burst start
	always_ff @(posedge clk) begin
		if (start) begin
			addr_q   <= i_read_addr;
			target   <= num_eff;
			word_cnt <= '0;
		end else if (state == rd_push) begin
			addr_q   <= addr_q + 1'b1;
			word_cnt <= word_cnt + 1'b1;
		end
		// Latency counter runs only through the wait cycles
		if (state == rd_issue) begin
			lat_cnt <= '0;
		end else if (state == rd_wait) begin
			lat_cnt <= lat_cnt + 1'b1;
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			rd_idle:  if (i_read_req) next_state = rd_claim;
			rd_claim: if (i_grant) next_state = rd_issue;
			rd_issue: next_state = rd_wait;
			// Leave after READ_LAT wait cycles
			rd_wait:  if (lat_cnt == LAT_W'(READ_LAT - 1)) next_state = rd_push;
			rd_push:  next_state = (word_cnt + 1'b1 < target) ? rd_issue : rd_done;
			rd_done:  next_state = rd_stop;
			// Hold until the host drops its request
			rd_stop:  if (!i_read_req) next_state = rd_idle;
			default:  next_state = rd_idle;
		endcase
	end

	// Claim stays high for the whole burst, dropped on done
	assign o_claim      = state inside {rd_claim, rd_issue, rd_wait, rd_push};
	assign o_bus_en     = state inside {rd_issue, rd_wait, rd_push};
	assign o_bus_addr   = addr_q;
	assign o_burst_done = (state == rd_done);

	// Read cache, filled from the RAM, drained by the host
	line_cache #(
		.DATA_W      (DATA_W),
		.CACHE_DEPTH (CACHE_DEPTH)
	) u_read_cache (
		.clk         (clk),
		.resetN      (resetN),
		.i_push      (state == rd_push),
		.i_push_data (i_bram_rdata),
		.i_pop       (pop),
		.o_head      (o_request_data),
		.o_empty     (),
		.o_full      (),
		.o_count     ()
	);

endmodule

// ==== hw/line_cache.sv ====
`timescale 1ns/1ps

module line_cache
	import bram_bus_pkg::*, burst_ctrl_pkg::*;
#(
	parameter int DATA_W      = BRAM_DATA_W_DEF,
	parameter int CACHE_DEPTH = CACHE_DEPTH_DEF
) (
	input  logic                           clk,
	input  logic                           resetN,
	input  logic                           i_push,
	input  logic [DATA_W-1:0]              i_push_data,
	input  logic                           i_pop,
	output logic [DATA_W-1:0]              o_head,
	output logic                           o_empty,
	output logic                           o_full,
	output logic [$clog2(CACHE_DEPTH):0]   o_count
);

	localparam int PTR_W = (CACHE_DEPTH > 1) ? $clog2(CACHE_DEPTH) : 1;
	localparam int CNT_W = $clog2(CACHE_DEPTH) + 1;

	logic [DATA_W-1:0] mem [CACHE_DEPTH];
	logic [PTR_W-1:0]  wr_ptr;
	logic [PTR_W-1:0]  rd_ptr;
	logic              do_push;
	logic              do_pop;

	// Circular pointer step, wraps for any depth
	function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(CACHE_DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	// Status straight from the fill counter
	assign o_empty = (o_count == '0);
	assign o_full  = (o_count == CNT_W'(CACHE_DEPTH));

	// Full drops a push, empty ignores a pop
	assign do_push = i_push && !o_full;
	assign do_pop  = i_pop && !o_empty;

	// First word falls through, no read delay on the head
	assign o_head = mem[rd_ptr];

	// Storage array
	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= i_push_data;
		end
	end

	// Pointers and fill count
	always_ff @(posedge clk) begin
		if (!resetN) begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			o_count <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= ptr_next(wr_ptr);
			end
			if (do_pop) begin
				rd_ptr <= ptr_next(rd_ptr);
			end
			// Simultaneous push and pop leave the fill unchanged
			case ({do_push, do_pop})
				2'b10:   o_count <= o_count + 1'b1;
				2'b01:   o_count <= o_count - 1'b1;
				default: o_count <= o_count;
			endcase
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Checks on the host and engine side of the cache

	a_push_not_full: assert property (@(posedge clk) disable iff (!resetN)
		i_push |-> !o_full)
		else $error("line_cache: push into a full cache dropped");

	a_pop_not_empty: assert property (@(posedge clk) disable iff (!resetN)
		i_pop |-> !o_empty)
		else $error("line_cache: pop of an empty cache ignored");

endmodule

// ==== hw/burst_ctrl_pkg.sv ====
package burst_ctrl_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Burst counting and cache sizing

	// Width of a burst word count from the host
	localparam int BURST_LEN_W = 16;

	typedef logic [BURST_LEN_W-1:0] burst_len_t;

	// Words held by each cache
	localparam int CACHE_DEPTH_DEF = 256;

	////////////////////////////////////////////////////////////////////////////
	// Bus ownership semaphore

	typedef enum logic [1:0] {
		owner_none  = 2'b00,
		owner_read  = 2'b01,
		owner_write = 2'b10
	} bus_owner_t;

	////////////////////////////////////////////////////////////////////////////
	// Engine state encodings

	// Read side, one word per issue/wait/push loop
	typedef enum logic [2:0] {
		rd_idle,
		rd_claim,
		rd_issue,
		rd_wait,
		rd_push,
		rd_done,
		rd_stop
	} rd_state_t;

	// Write side, four cycles per word
	typedef enum logic [2:0] {
		wr_idle,
		wr_claim,
		wr_enable,
		wr_assert,
		wr_remove,
		wr_pause,
		wr_done
	} wr_state_t;

endpackage

// ==== hw/bram_bus_pkg.sv ====
package bram_bus_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Single-port block RAM defaults

	// Word address width of the RAM port
	localparam int BRAM_ADDR_W_DEF = 15;

	// Data word width, shared by the RAM and both caches
	localparam int BRAM_DATA_W_DEF = 32;

	// Words in the RAM, one per address
	localparam int BRAM_DEPTH_DEF = 2 ** BRAM_ADDR_W_DEF;

	// Cycles from an enabled address to valid read data
	// Matches the four-deep wait chain of the read engine
	localparam int BRAM_READ_LAT_DEF = 4;

endpackage
